//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_rob_top
FILELIST  ?= rob.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- rob.f
+incdir+.
rob_pkg.sv
rob_entry.sv
rob_ptr_ctrl.sv
rob_commit.sv
rob_top.sv
tb_clk_gen.sv
tb_rob_top.sv

//--- rob_commit.sv
`default_nettype none
`include "rob_defs.svh"

module rob_commit
  import rob_pkg::*;
(
  input  wire [`ROB_DEPTH-1:0]  i_valid,
  input  wire [`CMT_ID_W-1:0]   i_cmt_id [`ROB_DEPTH],
  input  wire [`VADDR_W-1:0]    i_pc [`ROB_DEPTH],
  input  wire [`DISP_SIZE-1:0]  i_grp [`ROB_DEPTH],
  input  wire [`DISP_SIZE-1:0]  i_done_grp [`ROB_DEPTH],
  input  wire [`DISP_SIZE-1:0]  i_dead [`ROB_DEPTH],
  input  wire [`DISP_SIZE-1:0]  i_except_valid [`ROB_DEPTH],
  input  wire except_t          i_except_cause [`ROB_DEPTH][`DISP_SIZE],
  input  wire [`XLEN_W-1:0]     i_except_tval [`ROB_DEPTH][`DISP_SIZE],
  input  wire [`DISP_SIZE-1:0]  i_redirect_valid [`ROB_DEPTH],
  input  wire [`VADDR_W-1:0]    i_redirect_vaddr [`ROB_DEPTH][`DISP_SIZE],
  input  wire [`ROB_DEPTH-1:0]  i_block_all_done,
  input  wire [`ROB_IDX_W-1:0]  i_head_idx,
  output logic                  o_commit,
  output logic                  o_kill,
  output logic                  o_commit_valid,
  output logic [`CMT_ID_W-1:0]  o_commit_cmt_id,
  output logic [`DISP_SIZE-1:0] o_commit_dead_grp,
  output logic                  o_commit_except_valid,
  output except_t               o_commit_except_cause,
  output logic [`XLEN_W-1:0]    o_commit_except_tval,
  output logic [`VADDR_W-1:0]   o_commit_except_pc,
  output logic                  o_commit_redirect_valid,
  output logic [`VADDR_W-1:0]   o_commit_redirect_vaddr
);

  logic [`DISP_SIZE-1:0] w_live;
  logic [`DISP_SIZE-1:0] w_exc;
  logic [`DISP_SIZE-1:0] w_rdr;
  logic [`DISP_SIZE-1:0] w_exc_oh;
  logic [`DISP_SIZE-1:0] w_rdr_oh;
  logic [DISP_IDX_W-1:0] w_exc_idx;
  logic [DISP_IDX_W-1:0] w_rdr_idx;

  // Head entry retires once every slot is done or dead
  assign o_commit = i_valid[i_head_idx] & i_block_all_done[i_head_idx];

  // -------------------------------------------------------------------------
  // Exception and redirect select, oldest slot first
  // -------------------------------------------------------------------------
  assign w_live = i_grp[i_head_idx] & i_done_grp[i_head_idx] & ~i_dead[i_head_idx];
  assign w_exc  = w_live & i_except_valid[i_head_idx];
  assign w_rdr  = w_live & i_redirect_valid[i_head_idx];

  assign w_exc_oh  = w_exc & (~w_exc + 1'b1);  // Lowest set bit
  assign w_rdr_oh  = w_rdr & (~w_rdr + 1'b1);
  assign w_exc_idx = encode_grp(w_exc_oh);
  assign w_rdr_idx = encode_grp(w_rdr_oh);

  assign o_commit_except_valid   = o_commit & (|w_exc);
  assign o_commit_redirect_valid = o_commit & ~(|w_exc) & (|w_rdr);
  assign o_kill                  = o_commit_except_valid | o_commit_redirect_valid;

  assign o_commit_valid    = o_commit;
  assign o_commit_cmt_id   = i_cmt_id[i_head_idx];
  assign o_commit_dead_grp = i_dead[i_head_idx] & i_grp[i_head_idx];

  assign o_commit_except_cause = i_except_cause[i_head_idx][w_exc_idx];
  assign o_commit_except_tval  = i_except_tval[i_head_idx][w_exc_idx];
  // 4-byte slots from the group PC
  assign o_commit_except_pc    = i_pc[i_head_idx] + (`VADDR_W'(w_exc_idx) << 2);

  assign o_commit_redirect_vaddr = i_redirect_vaddr[i_head_idx][w_rdr_idx];

endmodule

`default_nettype wire

//--- rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// ---------------------------------------------------------------------------
// ROB geometry
// ---------------------------------------------------------------------------
`define ROB_DEPTH     8
`define ROB_IDX_W     3
`define CMT_ID_W      4   // Index plus wrap bit

// Dispatch and completion
`define DISP_SIZE     2
`define CMT_BUS_SIZE  2

// Branch tags in flight and the branch mask width
`define BRTAG_NUM     4
`define BRTAG_W       2

// Address and data widths
`define VADDR_W       32
`define XLEN_W        32

`endif

//--- rob_entry.sv
`default_nettype none
`include "rob_defs.svh"

module rob_entry
  import rob_pkg::*;
(
  input  wire                      i_clk,
  input  wire                      i_reset_n,
  input  wire [`CMT_ID_W-1:0]      i_cmt_id,
  input  wire                      i_load_valid,
  input  wire [`VADDR_W-1:0]       i_load_pc,
  input  wire [`DISP_SIZE-1:0]     i_load_slot_valid,
  input  wire [`DISP_SIZE-1:0]     i_load_illegal,
  input  wire [`BRTAG_NUM-1:0]     i_load_br_mask [`DISP_SIZE],
  input  wire [`CMT_BUS_SIZE-1:0]  i_done_valid,
  input  wire [`CMT_ID_W-1:0]      i_done_cmt_id [`CMT_BUS_SIZE],
  input  wire [`DISP_SIZE-1:0]     i_done_grp [`CMT_BUS_SIZE],
  input  wire [`CMT_BUS_SIZE-1:0]  i_done_except_valid,
  input  wire except_t             i_done_except_cause [`CMT_BUS_SIZE],
  input  wire [`XLEN_W-1:0]        i_done_except_tval [`CMT_BUS_SIZE],
  input  wire                      i_br_update,
  input  wire [`BRTAG_W-1:0]       i_br_tag,
  input  wire                      i_br_dead,
  input  wire                      i_br_mispredict,
  input  wire [`CMT_ID_W-1:0]      i_br_cmt_id,
  input  wire [`DISP_SIZE-1:0]     i_br_grp,
  input  wire [`VADDR_W-1:0]       i_br_target,
  input  wire                      i_commit_finish,
  input  wire                      i_kill,
  output logic                     o_valid,
  output logic [`VADDR_W-1:0]      o_pc,
  output logic [`DISP_SIZE-1:0]    o_grp,
  output logic [`DISP_SIZE-1:0]    o_done_grp,
  output logic [`DISP_SIZE-1:0]    o_dead,
  output logic [`DISP_SIZE-1:0]    o_except_valid,
  output except_t                  o_except_cause [`DISP_SIZE],
  output logic [`XLEN_W-1:0]       o_except_tval [`DISP_SIZE],
  output logic [`DISP_SIZE-1:0]    o_redirect_valid,
  output logic [`VADDR_W-1:0]      o_redirect_vaddr [`DISP_SIZE],
  output logic                     o_block_all_done
);

  logic                  r_valid, w_valid;
  logic [`VADDR_W-1:0]   r_pc, w_pc;
  logic [`DISP_SIZE-1:0] r_grp, w_grp;
  logic [`DISP_SIZE-1:0] r_done, w_done;
  logic [`DISP_SIZE-1:0] r_dead, w_dead;
  logic [`BRTAG_NUM-1:0] r_br_mask [`DISP_SIZE];
  logic [`BRTAG_NUM-1:0] w_br_mask [`DISP_SIZE];
  logic [`DISP_SIZE-1:0] r_except_valid, w_except_valid;
  except_t               r_except_cause [`DISP_SIZE];
  except_t               w_except_cause [`DISP_SIZE];
  logic [`XLEN_W-1:0]    r_except_tval [`DISP_SIZE];
  logic [`XLEN_W-1:0]    w_except_tval [`DISP_SIZE];
  logic [`DISP_SIZE-1:0] r_redirect_valid, w_redirect_valid;
  logic [`VADDR_W-1:0]   r_redirect_vaddr [`DISP_SIZE];
  logic [`VADDR_W-1:0]   w_redirect_vaddr [`DISP_SIZE];

  logic [`DISP_SIZE-1:0] w_rpt_hit;
  logic [`DISP_SIZE-1:0] w_rpt_except_valid;
  except_t               w_rpt_except_cause [`DISP_SIZE];
  logic [`XLEN_W-1:0]    w_rpt_except_tval [`DISP_SIZE];

  // -------------------------------------------------------------------------
  // Done report match per slot
  // -------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < `DISP_SIZE; d++) begin
      w_rpt_hit[d]          = 1'b0;
      w_rpt_except_valid[d] = 1'b0;
      w_rpt_except_cause[d] = NO_EXCEPT;
      w_rpt_except_tval[d]  = '0;
      for (int c = 0; c < `CMT_BUS_SIZE; c++) begin
        if (i_done_valid[c] && (i_done_cmt_id[c] == i_cmt_id) &&
            (i_done_grp[c] == (`DISP_SIZE'(1) << d))) begin
          w_rpt_hit[d]          = 1'b1;
          w_rpt_except_valid[d] = i_done_except_valid[c];
          w_rpt_except_cause[d] = i_done_except_cause[c];
          w_rpt_except_tval[d]  = i_done_except_tval[c];
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------
  always_comb begin
    w_valid          = r_valid;
    w_pc             = r_pc;
    w_grp            = r_grp;
    w_done           = r_done;
    w_dead           = r_dead;
    w_br_mask        = r_br_mask;
    w_except_valid   = r_except_valid;
    w_except_cause   = r_except_cause;
    w_except_tval    = r_except_tval;
    w_redirect_valid = r_redirect_valid;
    w_redirect_vaddr = r_redirect_vaddr;

    if (i_load_valid) begin
      w_valid          = 1'b1;
      w_pc             = i_load_pc;
      w_grp            = i_load_slot_valid;
      w_dead           = {`DISP_SIZE{i_kill}};  // Flush in progress
      w_redirect_valid = '0;
      for (int d = 0; d < `DISP_SIZE; d++) begin
        // Illegal slots never execute
        w_br_mask[d]      = i_load_br_mask[d];
        w_done[d]         = i_load_slot_valid[d] & i_load_illegal[d];
        w_except_valid[d] = i_load_slot_valid[d] & i_load_illegal[d];
        w_except_cause[d] = i_load_illegal[d] ? ILLEGAL_INST : NO_EXCEPT;
        w_except_tval[d]  = '0;
      end
    end else if (r_valid) begin
      if (i_commit_finish && o_block_all_done) begin
        w_valid = 1'b0;
      end
      for (int d = 0; d < `DISP_SIZE; d++) begin
        if (w_rpt_hit[d]) begin
          w_done[d] = 1'b1;
          if (!r_dead[d]) begin
            w_except_valid[d] = w_rpt_except_valid[d];
            w_except_cause[d] = w_rpt_except_cause[d];
            w_except_tval[d]  = w_rpt_except_tval[d];
          end
        end
      end
      w_dead = r_dead | {`DISP_SIZE{i_kill}};
      // Redirect recorded in the entry owning the branch
      if (i_br_update && (i_br_cmt_id == i_cmt_id) && !i_br_dead && i_br_mispredict) begin
        w_redirect_valid[encode_grp(i_br_grp)] = 1'b1;
        w_redirect_vaddr[encode_grp(i_br_grp)] = i_br_target;
      end
    end

    // Also covers a group loaded this cycle
    if (i_br_update && w_valid) begin
      for (int d = 0; d < `DISP_SIZE; d++) begin
        if (w_grp[d] && is_br_flush_target(w_br_mask[d], i_br_tag, i_br_dead,
                                            i_br_mispredict)) begin
          w_done[d] = 1'b1;
          w_dead[d] = 1'b1;
        end
        w_br_mask[d][i_br_tag] = 1'b0;  // Tag resolved
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid          <= 1'b0;
      r_done           <= '0;
      r_dead           <= '0;
      r_except_valid   <= '0;
      r_redirect_valid <= '0;
    end else begin
      r_valid          <= w_valid;
      r_done           <= w_done;
      r_dead           <= w_dead;
      r_except_valid   <= w_except_valid;
      r_redirect_valid <= w_redirect_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_pc             <= w_pc;
    r_grp            <= w_grp;
    r_br_mask        <= w_br_mask;
    r_except_cause   <= w_except_cause;
    r_except_tval    <= w_except_tval;
    r_redirect_vaddr <= w_redirect_vaddr;
  end

  assign o_valid          = r_valid;
  assign o_pc             = r_pc;
  assign o_grp            = r_grp;
  assign o_done_grp       = r_done;
  assign o_dead           = r_dead;
  assign o_except_valid   = r_except_valid;
  assign o_except_cause   = r_except_cause;
  assign o_except_tval    = r_except_tval;
  assign o_redirect_valid = r_redirect_valid;
  assign o_redirect_vaddr = r_redirect_vaddr;
  assign o_block_all_done = r_valid & (((r_done | r_dead) & r_grp) == r_grp);

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none
`include "rob_defs.svh"

package rob_pkg;

  localparam int DISP_IDX_W = (`DISP_SIZE > 1) ? $clog2(`DISP_SIZE) : 1;

  // Codes follow mcause
  typedef enum logic [3:0] {
    NO_EXCEPT    = 4'd0,
    ILLEGAL_INST = 4'd2,
    LOAD_FAULT   = 4'd5,
    STORE_FAULT  = 4'd7,
    ECALL        = 4'd11
  } except_t;

  // Slot depends on a branch that resolved as mispredicted
  function automatic logic is_br_flush_target(
    input logic [`BRTAG_NUM-1:0] br_mask,
    input logic [`BRTAG_W-1:0]   br_tag,
    input logic                  br_dead,
    input logic                  br_mispredict
  );
    return br_mask[br_tag] & ~br_dead & br_mispredict;
  endfunction

  // One-hot group slot to slot index
  function automatic logic [DISP_IDX_W-1:0] encode_grp(
    input logic [`DISP_SIZE-1:0] grp
  );
    logic [DISP_IDX_W-1:0] idx;
    idx = '0;
    for (int d = 0; d < `DISP_SIZE; d++) begin
      if (grp[d]) begin
        idx = idx | DISP_IDX_W'(d);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- rob_ptr_ctrl.sv
`default_nettype none
`include "rob_defs.svh"

module rob_ptr_ctrl (
  input  wire                    i_clk,
  input  wire                    i_reset_n,
  input  wire                    i_disp_valid,
  input  wire                    i_commit,
  output logic [`ROB_DEPTH-1:0]  o_load,
  output logic [`CMT_ID_W-1:0]   o_tail_id,
  output logic [`ROB_IDX_W-1:0]  o_head_idx,
  output logic                   o_rob_full
);

  logic [`CMT_ID_W-1:0] r_head;
  logic [`CMT_ID_W-1:0] r_tail;
  logic [`CMT_ID_W-1:0] w_count;
  logic                 w_push;

  // Wrap bits make a full ROB distinct from an empty one
  assign w_count    = r_tail - r_head;
  assign o_rob_full = (w_count == `CMT_ID_W'(`ROB_DEPTH));
  assign w_push     = i_disp_valid & ~o_rob_full;  // Ignored while full

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
    end else begin
      if (w_push) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_commit) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // One-hot load strobe at the tail
  assign o_load = w_push ? (`ROB_DEPTH'(1) << r_tail[`ROB_IDX_W-1:0]) : '0;

  assign o_tail_id  = r_tail;
  assign o_head_idx = r_head[`ROB_IDX_W-1:0];

endmodule

`default_nettype wire

//--- rob_top.sv
`default_nettype none
`include "rob_defs.svh"

module rob_top
  import rob_pkg::*;
(
  input  wire                     i_clk,
  input  wire                     i_reset_n,
  input  wire                     i_disp_valid,
  input  wire [`VADDR_W-1:0]      i_disp_pc,
  input  wire [`DISP_SIZE-1:0]    i_disp_slot_valid,
  input  wire [`DISP_SIZE-1:0]    i_disp_illegal,
  input  wire [`BRTAG_NUM-1:0]    i_disp_br_mask [`DISP_SIZE],
  output logic [`CMT_ID_W-1:0]    o_disp_cmt_id,
  output logic                    o_rob_full,
  input  wire [`CMT_BUS_SIZE-1:0] i_done_valid,
  input  wire [`CMT_ID_W-1:0]     i_done_cmt_id [`CMT_BUS_SIZE],
  input  wire [`DISP_SIZE-1:0]    i_done_grp [`CMT_BUS_SIZE],
  input  wire [`CMT_BUS_SIZE-1:0] i_done_except_valid,
  input  wire except_t            i_done_except_cause [`CMT_BUS_SIZE],
  input  wire [`XLEN_W-1:0]       i_done_except_tval [`CMT_BUS_SIZE],
  input  wire                     i_br_update,
  input  wire [`BRTAG_W-1:0]      i_br_tag,
  input  wire                     i_br_dead,
  input  wire                     i_br_mispredict,
  input  wire [`CMT_ID_W-1:0]     i_br_cmt_id,
  input  wire [`DISP_SIZE-1:0]    i_br_grp,
  input  wire [`VADDR_W-1:0]      i_br_target,
  output logic                    o_commit_valid,
  output logic [`CMT_ID_W-1:0]    o_commit_cmt_id,
  output logic [`DISP_SIZE-1:0]   o_commit_dead_grp,
  output logic                    o_commit_except_valid,
  output except_t                 o_commit_except_cause,
  output logic [`XLEN_W-1:0]      o_commit_except_tval,
  output logic [`VADDR_W-1:0]     o_commit_except_pc,
  output logic                    o_commit_redirect_valid,
  output logic [`VADDR_W-1:0]     o_commit_redirect_vaddr
);

  logic [`ROB_DEPTH-1:0]  w_load;
  logic [`ROB_IDX_W-1:0]  w_head_idx;
  logic                   w_commit;
  logic                   w_kill;
  logic [`CMT_ID_W-1:0]   w_cmt_id [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0]  w_valid;
  logic [`VADDR_W-1:0]    w_pc [`ROB_DEPTH];
  logic [`DISP_SIZE-1:0]  w_grp [`ROB_DEPTH];
  logic [`DISP_SIZE-1:0]  w_done_grp [`ROB_DEPTH];
  logic [`DISP_SIZE-1:0]  w_dead [`ROB_DEPTH];
  logic [`DISP_SIZE-1:0]  w_except_valid [`ROB_DEPTH];
  except_t                w_except_cause [`ROB_DEPTH][`DISP_SIZE];
  logic [`XLEN_W-1:0]     w_except_tval [`ROB_DEPTH][`DISP_SIZE];
  logic [`DISP_SIZE-1:0]  w_redirect_valid [`ROB_DEPTH];
  logic [`VADDR_W-1:0]    w_redirect_vaddr [`ROB_DEPTH][`DISP_SIZE];
  logic [`ROB_DEPTH-1:0]  w_block_all_done;

  rob_ptr_ctrl u_ptr_ctrl (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_commit   (w_commit),
    .o_load     (w_load),
    .o_tail_id  (o_disp_cmt_id),
    .o_head_idx (w_head_idx),
    .o_rob_full (o_rob_full)
  );

  for (genvar g = 0; g < `ROB_DEPTH; g++) begin : g_entry
    // Entries below the tail index hold the current wrap, the rest the previous one
    assign w_cmt_id[g] = {(`ROB_IDX_W'(g) < o_disp_cmt_id[`ROB_IDX_W-1:0]) ?
                          o_disp_cmt_id[`CMT_ID_W-1] : ~o_disp_cmt_id[`CMT_ID_W-1],
                          `ROB_IDX_W'(g)};

    rob_entry u_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_cmt_id            (w_cmt_id[g]),
      .i_load_valid        (w_load[g]),
      .i_load_pc           (i_disp_pc),
      .i_load_slot_valid   (i_disp_slot_valid),
      .i_load_illegal      (i_disp_illegal),
      .i_load_br_mask      (i_disp_br_mask),
      .i_done_valid        (i_done_valid),
      .i_done_cmt_id       (i_done_cmt_id),
      .i_done_grp          (i_done_grp),
      .i_done_except_valid (i_done_except_valid),
      .i_done_except_cause (i_done_except_cause),
      .i_done_except_tval  (i_done_except_tval),
      .i_br_update         (i_br_update),
      .i_br_tag            (i_br_tag),
      .i_br_dead           (i_br_dead),
      .i_br_mispredict     (i_br_mispredict),
      .i_br_cmt_id         (i_br_cmt_id),
      .i_br_grp            (i_br_grp),
      .i_br_target         (i_br_target),
      .i_commit_finish     (w_commit & (w_head_idx == `ROB_IDX_W'(g))),
      .i_kill              (w_kill),
      .o_valid             (w_valid[g]),
      .o_pc                (w_pc[g]),
      .o_grp               (w_grp[g]),
      .o_done_grp          (w_done_grp[g]),
      .o_dead              (w_dead[g]),
      .o_except_valid      (w_except_valid[g]),
      .o_except_cause      (w_except_cause[g]),
      .o_except_tval       (w_except_tval[g]),
      .o_redirect_valid    (w_redirect_valid[g]),
      .o_redirect_vaddr    (w_redirect_vaddr[g]),
      .o_block_all_done    (w_block_all_done[g])
    );
  end

  rob_commit u_commit (
    .i_valid                 (w_valid),
    .i_cmt_id                (w_cmt_id),
    .i_pc                    (w_pc),
    .i_grp                   (w_grp),
    .i_done_grp              (w_done_grp),
    .i_dead                  (w_dead),
    .i_except_valid          (w_except_valid),
    .i_except_cause          (w_except_cause),
    .i_except_tval           (w_except_tval),
    .i_redirect_valid        (w_redirect_valid),
    .i_redirect_vaddr        (w_redirect_vaddr),
    .i_block_all_done        (w_block_all_done),
    .i_head_idx              (w_head_idx),
    .o_commit                (w_commit),
    .o_kill                  (w_kill),
    .o_commit_valid          (o_commit_valid),
    .o_commit_cmt_id         (o_commit_cmt_id),
    .o_commit_dead_grp       (o_commit_dead_grp),
    .o_commit_except_valid   (o_commit_except_valid),
    .o_commit_except_cause   (o_commit_except_cause),
    .o_commit_except_tval    (o_commit_except_tval),
    .o_commit_except_pc      (o_commit_except_pc),
    .o_commit_redirect_valid (o_commit_redirect_valid),
    .o_commit_redirect_vaddr (o_commit_redirect_vaddr)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;  // Released on an edge
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- tb_rob_top.sv
`default_nettype none
`include "rob_defs.svh"

module tb_rob_top
  import rob_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int OP_IDLE = 0;
  localparam int OP_DISP = 1;
  localparam int OP_DONE = 2;
  localparam int OP_BR   = 3;

  typedef struct {
    int          test;
    int          op;
    logic [31:0] addr;      // PC or branch target
    logic [1:0]  sv, ill;
    logic [3:0]  m0, m1;
    logic [3:0]  id0, id1;  // id0 is also the branch owner
    logic [1:0]  g0, g1;
    logic [1:0]  dv;
    logic        exc;       // Port 0 reports a load fault
    logic [1:0]  tag;
    logic        mis;
    logic        cv;
    logic [1:0]  dgrp;
    logic        ev;
    except_t     cause;
    logic [31:0] epc;
    logic        tval_lfsr;
    logic        rv;
    logic [31:0] rva;
  } row_t;

  logic clk, reset_n;
  logic                     disp_valid;
  logic [`VADDR_W-1:0]      disp_pc;
  logic [`DISP_SIZE-1:0]    disp_slot_valid, disp_illegal;
  logic [`BRTAG_NUM-1:0]    disp_br_mask [`DISP_SIZE];
  logic [`CMT_ID_W-1:0]     disp_cmt_id;
  logic                     rob_full;
  logic [`CMT_BUS_SIZE-1:0] done_valid, done_except_valid;
  logic [`CMT_ID_W-1:0]     done_cmt_id [`CMT_BUS_SIZE];
  logic [`DISP_SIZE-1:0]    done_grp [`CMT_BUS_SIZE];
  except_t                  done_except_cause [`CMT_BUS_SIZE];
  logic [`XLEN_W-1:0]       done_except_tval [`CMT_BUS_SIZE];
  logic                     br_update, br_dead, br_mispredict;
  logic [`BRTAG_W-1:0]      br_tag;
  logic [`CMT_ID_W-1:0]     br_cmt_id;
  logic [`DISP_SIZE-1:0]    br_grp;
  logic [`VADDR_W-1:0]      br_target;
  logic                     commit_valid, commit_except_valid, commit_redirect_valid;
  logic [`CMT_ID_W-1:0]     commit_cmt_id;
  logic [`DISP_SIZE-1:0]    commit_dead_grp;
  except_t                  commit_except_cause;
  logic [`XLEN_W-1:0]       commit_except_tval;
  logic [`VADDR_W-1:0]      commit_except_pc, commit_redirect_vaddr;

  row_t        rows[$];
  logic [3:0]  model_q[$];  // Ids in flight with the oldest first
  logic [3:0]  model_tail;
  logic        pend_pop;
  logic [15:0] lfsr_state;
  logic [31:0] last_tval;
  int          errors, checks, test_errs;
  string       test_name [6] = '{"reset and fill", "out-of-order done", "illegal at dispatch",
                                 "load fault flush", "branch mispredict", "branch resolved"};

  tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

  rob_top i_rob_top (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_disp_valid(disp_valid), .i_disp_pc(disp_pc), .i_disp_slot_valid(disp_slot_valid),
    .i_disp_illegal(disp_illegal), .i_disp_br_mask(disp_br_mask),
    .o_disp_cmt_id(disp_cmt_id), .o_rob_full(rob_full),
    .i_done_valid(done_valid), .i_done_cmt_id(done_cmt_id), .i_done_grp(done_grp),
    .i_done_except_valid(done_except_valid), .i_done_except_cause(done_except_cause),
    .i_done_except_tval(done_except_tval),
    .i_br_update(br_update), .i_br_tag(br_tag), .i_br_dead(br_dead),
    .i_br_mispredict(br_mispredict), .i_br_cmt_id(br_cmt_id), .i_br_grp(br_grp),
    .i_br_target(br_target),
    .o_commit_valid(commit_valid), .o_commit_cmt_id(commit_cmt_id),
    .o_commit_dead_grp(commit_dead_grp), .o_commit_except_valid(commit_except_valid),
    .o_commit_except_cause(commit_except_cause), .o_commit_except_tval(commit_except_tval),
    .o_commit_except_pc(commit_except_pc), .o_commit_redirect_valid(commit_redirect_valid),
    .o_commit_redirect_vaddr(commit_redirect_vaddr)
  );

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_tval(output logic [31:0] v);
    v = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  // -------------------------------------------------------------------------
  // Table construction
  // -------------------------------------------------------------------------
  function automatic row_t blank_row(input int test, input int op);
    row_t r;
    r = '{default: '0, cause: NO_EXCEPT};
    r.test = test;
    r.op   = op;
    return r;
  endfunction

  task automatic idle_row(input int test);
    rows.push_back(blank_row(test, OP_IDLE));
  endtask

  task automatic dispatch_row(input int test, input logic [31:0] pc, input logic [1:0] sv,
                              input logic [1:0] ill, input logic [3:0] m0, input logic [3:0] m1);
    row_t r;
    r = blank_row(test, OP_DISP);
    r.addr = pc;
    r.sv   = sv;
    r.ill  = ill;
    r.m0   = m0;
    r.m1   = m1;
    rows.push_back(r);
  endtask

  task automatic done_row(input int test, input logic [3:0] id0, input logic [1:0] g0,
                          input logic [3:0] id1, input logic [1:0] g1, input logic [1:0] dv,
                          input logic exc);
    row_t r;
    r = blank_row(test, OP_DONE);
    r.id0 = id0;
    r.g0  = g0;
    r.id1 = id1;
    r.g1  = g1;
    r.dv  = dv;
    r.exc = exc;
    rows.push_back(r);
  endtask

  task automatic branch_row(input int test, input logic [1:0] tag, input logic mis,
                            input logic [3:0] id, input logic [1:0] grp, input logic [31:0] tgt);
    row_t r;
    r = blank_row(test, OP_BR);
    r.tag  = tag;
    r.mis  = mis;
    r.id0  = id;
    r.g0   = grp;
    r.addr = tgt;
    rows.push_back(r);
  endtask

  // Expected commit in the cycle after the last row is taken
  task automatic set_commit(input logic [1:0] dgrp, input logic ev, input except_t cause,
                            input logic [31:0] epc, input logic tl, input logic rv,
                            input logic [31:0] rva);
    row_t r;
    r = rows.pop_back();
    r.cv        = 1'b1;
    r.dgrp      = dgrp;
    r.ev        = ev;
    r.cause     = cause;
    r.epc       = epc;
    r.tval_lfsr = tl;
    r.rv        = rv;
    r.rva       = rva;
    rows.push_back(r);
  endtask

  task automatic build_table;
    idle_row(0);
    for (int i = 0; i < 9; i++) begin
      dispatch_row(0, 32'h1000 + 32'(i * 16), 2'b11, 2'b00, 4'h0, 4'h0);  // Ninth is ignored
    end
    done_row(1, 4'd1, 2'b01, 4'd1, 2'b10, 2'b11, 1'b0);
    done_row(1, 4'd0, 2'b10, 4'd2, 2'b01, 2'b11, 1'b0);
    done_row(1, 4'd0, 2'b01, 4'd2, 2'b10, 2'b11, 1'b0);
    set_commit(2'b00, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(1);
    set_commit(2'b00, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(1);
    set_commit(2'b00, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(1);
    for (int id = 3; id < 8; id++) begin
      done_row(1, 4'(id), 2'b01, 4'(id), 2'b10, 2'b11, 1'b0);
      set_commit(2'b00, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    end
    idle_row(1);
    // Slot 1 illegal, so the fault PC is the group PC plus 4
    dispatch_row(2, 32'h0a0, 2'b11, 2'b10, 4'h0, 4'h0);
    dispatch_row(2, 32'h0b0, 2'b11, 2'b00, 4'h0, 4'h0);
    dispatch_row(2, 32'h0c0, 2'b11, 2'b00, 4'h0, 4'h0);
    done_row(2, 4'd8, 2'b01, 4'd0, 2'b00, 2'b01, 1'b0);
    set_commit(2'b00, 1'b1, ILLEGAL_INST, 32'h0a4, 1'b0, 1'b0, 32'h0);
    idle_row(2);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(2);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(2);
    dispatch_row(3, 32'h100, 2'b11, 2'b00, 4'h0, 4'h0);
    dispatch_row(3, 32'h110, 2'b11, 2'b00, 4'h0, 4'h0);
    dispatch_row(3, 32'h120, 2'b11, 2'b00, 4'h0, 4'h0);
    done_row(3, 4'd11, 2'b01, 4'd11, 2'b10, 2'b11, 1'b1);
    set_commit(2'b00, 1'b1, LOAD_FAULT, 32'h100, 1'b1, 1'b0, 32'h0);
    idle_row(3);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(3);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(3);
    // Branch in slot 0 of id 14 owns tag 1 and slot 1 depends on it
    dispatch_row(4, 32'h200, 2'b11, 2'b00, 4'h0, 4'b0010);
    dispatch_row(4, 32'h300, 2'b11, 2'b00, 4'b0010, 4'h0);
    dispatch_row(4, 32'h310, 2'b11, 2'b00, 4'b0010, 4'b0010);
    branch_row(4, 2'd1, 1'b1, 4'd14, 2'b01, 32'h400);
    done_row(4, 4'd14, 2'b01, 4'd14, 2'b10, 2'b11, 1'b0);
    set_commit(2'b10, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b1, 32'h400);
    idle_row(4);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(4);
    set_commit(2'b11, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(4);
    dispatch_row(5, 32'h500, 2'b11, 2'b00, 4'b0100, 4'h0);
    branch_row(5, 2'd2, 1'b0, 4'd1, 2'b01, 32'h600);
    done_row(5, 4'd1, 2'b10, 4'd0, 2'b00, 2'b01, 1'b0);
    done_row(5, 4'd1, 2'b01, 4'd0, 2'b00, 2'b01, 1'b0);
    set_commit(2'b00, 1'b0, NO_EXCEPT, 32'h0, 1'b0, 1'b0, 32'h0);
    idle_row(5);
  endtask

  // -------------------------------------------------------------------------
  // Drive and check
  // -------------------------------------------------------------------------
  task automatic drive_row(input row_t r);
    logic [31:0] tv;
    tv = '0;
    if (r.exc) begin
      draw_tval(tv);
      last_tval = tv;
    end
    disp_valid          <= (r.op == OP_DISP);
    disp_pc             <= r.addr;
    disp_slot_valid     <= r.sv;
    disp_illegal        <= r.ill;
    disp_br_mask[0]     <= r.m0;
    disp_br_mask[1]     <= r.m1;
    done_valid          <= (r.op == OP_DONE) ? r.dv : 2'b00;
    done_cmt_id[0]      <= r.id0;
    done_cmt_id[1]      <= r.id1;
    done_grp[0]         <= r.g0;
    done_grp[1]         <= r.g1;
    done_except_valid   <= {1'b0, r.exc};
    done_except_cause[0] <= r.exc ? LOAD_FAULT : NO_EXCEPT;
    done_except_tval[0] <= tv;
    br_update           <= (r.op == OP_BR);
    br_tag              <= r.tag;
    br_mispredict       <= r.mis;
    br_cmt_id           <= r.id0;
    br_grp              <= r.g0;
    br_target           <= r.addr;
  endtask

  task automatic check_row(input row_t r);
    logic acc;
    acc = (r.op == OP_DISP) && (model_q.size() < `ROB_DEPTH);
    if (pend_pop) begin
      void'(model_q.pop_front());
      pend_pop = 1'b0;
    end
    if (acc) begin
      model_q.push_back(model_tail);
      model_tail = model_tail + 1'b1;
    end
    compare("o_rob_full", 32'(rob_full), 32'(model_q.size() == `ROB_DEPTH));
    compare("o_disp_cmt_id", 32'(disp_cmt_id), 32'(model_tail));
    compare("o_commit_valid", 32'(commit_valid), 32'(r.cv));
    compare("o_commit_except_valid", 32'(commit_except_valid), 32'(r.ev));
    compare("o_commit_redirect_valid", 32'(commit_redirect_valid), 32'(r.rv));
    if (r.cv) begin
      if (model_q.size() == 0) begin
        $display("Commit expected at %0d ns but the model holds no entry", $time);
        errors++;
        test_errs++;
      end else begin
        compare("o_commit_cmt_id", 32'(commit_cmt_id), 32'(model_q[0]));
        pend_pop = 1'b1;
      end
      compare("o_commit_dead_grp", 32'(commit_dead_grp), 32'(r.dgrp));
    end
    if (r.ev) begin
      compare("o_commit_except_cause", 32'(commit_except_cause), 32'(r.cause));
      compare("o_commit_except_pc", commit_except_pc, r.epc);
      compare("o_commit_except_tval", commit_except_tval, r.tval_lfsr ? last_tval : 32'h0);
    end
    if (r.rv) begin
      compare("o_commit_redirect_vaddr", commit_redirect_vaddr, r.rva);
    end
  endtask

  initial begin
    disp_valid = 1'b0;
    disp_pc = '0;
    disp_slot_valid = '0;
    disp_illegal = '0;
    disp_br_mask = '{default: '0};
    done_valid = '0;
    done_cmt_id = '{default: '0};
    done_grp = '{default: '0};
    done_except_valid = '0;
    done_except_cause = '{default: NO_EXCEPT};
    done_except_tval = '{default: '0};
    br_update = 1'b0;
    br_tag = '0;
    br_dead = 1'b0;
    br_mispredict = 1'b0;
    br_cmt_id = '0;
    br_grp = '0;
    br_target = '0;
    lfsr_state = 16'd91;
    last_tval = '0;
    model_tail = '0;
    pend_pop = 1'b0;
    errors = 0;
    checks = 0;
    test_errs = 0;
    build_table();
    @(posedge reset_n);
    for (int k = 0; k <= rows.size(); k++) begin
      @(posedge clk);
      if (k < rows.size()) begin
        drive_row(rows[k]);
      end else begin
        drive_row(blank_row(0, OP_IDLE));
      end
      @(negedge clk);
      if (k > 0) begin
        check_row(rows[k-1]);
        if ((k == rows.size()) || (rows[k].test != rows[k-1].test)) begin
          $display("test %0d %s: %s", rows[k-1].test + 1, test_name[rows[k-1].test],
                   (test_errs == 0) ? "ok" : "errors");
          test_errs = 0;
        end
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog allows four cycles per row plus margin
  initial begin
    #1;
    #((rows.size() + 10) * 4 * 40);
    $display("Timeout: the run did not finish in the allowed time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
